//--- run_sim.sh
#!/bin/sh
# build and run the audio controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
  --top-module tb_ac97_ctrl -Mdir "$BUILD_DIR" -o tb_ac97_ctrl
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_ac97_ctrl" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

//--- sim.f
src/ac97_audio_pkg.sv
src/ac97_reg_pkg.sv
src/sample_strobe_gen.sv
src/sample_fifo.sv
src/ac97_bus_decode.sv
src/codec_reg_file.sv
src/ac97_read_mux.sv
src/ac97_ctrl_top.sv
tb/tb_clk_gen.sv
tb/tb_ac97_ctrl.sv

//--- src/ac97_audio_pkg.sv
// Audio sample types
`default_nettype none

package ac97_audio_pkg;

  // --------------------------------------------------------------------------
  // sample payloads
  // --------------------------------------------------------------------------
  typedef logic signed [15:0] sample_t;        // one line node sample

  typedef struct packed {
    sample_t right;                            // upper half
    sample_t left;                             // lower half
  } stereo_t;

  // --------------------------------------------------------------------------
  // fifo sizing
  // --------------------------------------------------------------------------
  localparam int unsigned FIFO_DEPTH_DEFAULT = 16;
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH_DEFAULT + 1);  // 0..depth

  typedef logic [FIFO_CNT_W-1:0] fifo_count_t;

endpackage

`default_nettype wire

//--- src/ac97_bus_decode.sv
// System bus request decoder
`timescale 1ns/1ps
`default_nettype none

module ac97_bus_decode
  import ac97_reg_pkg::*;
  import ac97_audio_pkg::*;
(
  input  wire      clk_adc_125mhz,
  input  wire      adc_rstn_i,
  input  bus_req_t req_i,
  input  wire      play_flush_i,               // restart play pairing at left
  input  wire      rec_flush_i,                // restart record pairing at left
  output bus_cmd_t cmd_o
);

  reg_off_t off;
  logic     play_wr;
  logic     rec_rd;
  logic     play_right_q;                      // next play write is the right half
  logic     rec_right_q;                       // next record read is the right half
  sample_t  play_left_q;                       // left half waiting for its right

  assign off     = req_i.addr[ADDR_DECODE_BITS-1:0];
  assign play_wr = req_i.wen && (off == ADDR_FIFO_PLAY);
  assign rec_rd  = req_i.ren && (off == ADDR_FIFO_REC);

  // --------------------------------------------------------------------------
  // command flags, combinational from request and pairing state
  // --------------------------------------------------------------------------
  always_comb begin
    cmd_o            = '0;
    cmd_o.any_access = req_i.wen || req_i.ren;
    if (req_i.wen) begin
      case (off)
        ADDR_FIFO_PLAY: begin
          cmd_o.play_push       = play_right_q;  // pair complete on right write
          cmd_o.play_pair.right = sample_t'(req_i.wdata[15:0]);
          cmd_o.play_pair.left  = play_left_q;
        end
        ADDR_FIFO_RESET: begin
          cmd_o.play_reset = req_i.wdata[RST_PLAY_BIT];
          cmd_o.rec_reset  = req_i.wdata[RST_REC_BIT];
        end
        ADDR_CODEC_ADDR: begin
          cmd_o.codec_cmd_valid = 1'b1;
          cmd_o.codec_addr      = req_i.wdata[6:1];  // byte to word address
          cmd_o.codec_read      = req_i.wdata[CODEC_RW_BIT];
        end
        ADDR_CODEC_WDATA: begin
          cmd_o.codec_wdata_valid = 1'b1;
          cmd_o.codec_wdata       = req_i.wdata[15:0];
        end
        default: ;                             // writes elsewhere are dropped
      endcase
    end
    if (req_i.ren) begin
      case (off)
        ADDR_FIFO_REC: begin
          cmd_o.sel_rec        = 1'b1;
          cmd_o.rec_half_right = rec_right_q;
          cmd_o.rec_pop        = rec_right_q;  // right half read frees the head
        end
        ADDR_STATUS:      cmd_o.sel_status = 1'b1;
        ADDR_CODEC_RDATA: cmd_o.sel_codec  = 1'b1;
        default:          cmd_o.sel_other  = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_right_q <= 1'b0;
      rec_right_q  <= 1'b0;
    end else begin
      if (play_flush_i) play_right_q <= 1'b0;
      else if (play_wr) play_right_q <= !play_right_q;
      if (rec_flush_i) rec_right_q <= 1'b0;
      else if (rec_rd) rec_right_q <= !rec_right_q;
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (play_wr && !play_right_q) play_left_q <= sample_t'(req_i.wdata[15:0]);
  end

endmodule

`default_nettype wire

//--- src/ac97_ctrl_top.sv
// Audio controller top level
`timescale 1ns/1ps
`default_nettype none

module ac97_ctrl_top
  import ac97_reg_pkg::*;
  import ac97_audio_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH    = FIFO_DEPTH_DEFAULT,
  parameter int unsigned SAMPLE_PERIOD = 2604  // 48 kHz at 125 MHz
) (
  input  wire       clk_adc_125mhz,
  input  wire       adc_rstn_i,
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  wire       sys_wen_i,
  input  wire       sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  input  stereo_t   line_in_i,
  output stereo_t   line_out_o,
  output logic      sample_strobe_o
);

  bus_req_t    req;
  bus_rsp_t    rsp;
  bus_cmd_t    cmd;
  logic        strobe;
  stereo_t     play_head;
  stereo_t     rec_head;
  fifo_count_t play_count;
  fifo_count_t rec_count;
  logic        play_empty;
  logic        rec_full;
  codec_data_t codec_rdata;
  logic        access_done;
  stereo_t     line_out_q;

  assign req = '{addr: sys_addr_i, wdata: sys_wdata_i, wen: sys_wen_i, ren: sys_ren_i};
  assign sys_rdata_o     = rsp.rdata;
  assign sys_ack_o       = rsp.ack;
  assign sample_strobe_o = strobe;
  assign line_out_o      = line_out_q;

  sample_strobe_gen #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) u_strobe (
    .clk_adc_125mhz, .adc_rstn_i, .strobe_o(strobe)
  );

  ac97_bus_decode u_decode (
    .clk_adc_125mhz, .adc_rstn_i, .req_i(req),
    .play_flush_i(cmd.play_reset), .rec_flush_i(cmd.rec_reset), .cmd_o(cmd)
  );

  // ------------------------------------------------------------------------
  // play: software pushes pairs, strobe drains to line out
  // ------------------------------------------------------------------------
  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(stereo_t)) play_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .flush_i(cmd.play_reset),
    .push_i(cmd.play_push), .data_i(cmd.play_pair), .pop_i(strobe),
    .head_o(play_head), .count_o(play_count), .empty_o(play_empty), .full_o()
  );

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) line_out_q <= '0;
    else if (strobe && !play_empty) line_out_q <= play_head;  // holds on underrun
  end

  // record: strobe captures line in, software drains halves
  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(stereo_t)) rec_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .flush_i(cmd.rec_reset),
    .push_i(strobe), .data_i(line_in_i), .pop_i(cmd.rec_pop),
    .head_o(rec_head), .count_o(rec_count), .empty_o(), .full_o(rec_full)
  );

  codec_reg_file u_codec (
    .clk_adc_125mhz, .adc_rstn_i, .cmd_i(cmd),
    .rdata_o(codec_rdata), .access_done_o(access_done)
  );

  ac97_read_mux #(.FIFO_DEPTH(FIFO_DEPTH)) u_read_mux (
    .clk_adc_125mhz, .adc_rstn_i, .cmd_i(cmd), .strobe_i(strobe),
    .rec_head_i(rec_head), .play_count_i(play_count), .rec_count_i(rec_count),
    .play_empty_i(play_empty), .rec_full_i(rec_full),
    .codec_rdata_i(codec_rdata), .access_done_i(access_done), .rsp_o(rsp)
  );

endmodule

`default_nettype wire

//--- src/ac97_read_mux.sv
// Read data and status stage
`timescale 1ns/1ps
`default_nettype none

module ac97_read_mux
  import ac97_reg_pkg::*;
  import ac97_audio_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
  input  wire         clk_adc_125mhz,
  input  wire         adc_rstn_i,
  input  bus_cmd_t    cmd_i,
  input  wire         strobe_i,                // sample tick
  input  stereo_t     rec_head_i,
  input  fifo_count_t play_count_i,
  input  fifo_count_t rec_count_i,
  input  wire         play_empty_i,
  input  wire         rec_full_i,
  input  codec_data_t codec_rdata_i,
  input  wire         access_done_i,
  output bus_rsp_t    rsp_o
);

  logic                 play_underrun_q;
  logic                 rec_overrun_q;
  logic                 codec_ready_q;
  logic [STAT_BITS-1:0] status;
  bus_data_t            rdata_q;
  logic                 ack_q;
  sample_t              rec_half;

  assign rec_half = cmd_i.rec_half_right ? rec_head_i.right : rec_head_i.left;

  always_comb begin
    status                     = '0;
    status[STAT_PLAY_FULL]     = (play_count_i == fifo_count_t'(FIFO_DEPTH));
    status[STAT_PLAY_HALF]     = (play_count_i <= fifo_count_t'(FIFO_DEPTH / 2));
    status[STAT_REC_FULL]      = rec_full_i;
    status[STAT_REC_EMPTY]     = (rec_count_i == '0);
    status[STAT_ACCESS_DONE]   = access_done_i;
    status[STAT_CODEC_READY]   = codec_ready_q;
    status[STAT_PLAY_UNDERRUN] = play_underrun_q;
    status[STAT_REC_OVERRUN]   = rec_overrun_q;
  end

  // --------------------------------------------------------------------------
  // sticky flags, fifo reset wins over a same-cycle set
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_underrun_q <= 1'b0;
      rec_overrun_q   <= 1'b0;
      codec_ready_q   <= 1'b0;
      ack_q           <= 1'b0;
      rdata_q         <= '0;
    end else begin
      codec_ready_q <= 1'b1;                   // ready one cycle after reset
      if (cmd_i.play_reset) play_underrun_q <= 1'b0;
      else if (strobe_i && play_empty_i) play_underrun_q <= 1'b1;
      if (cmd_i.rec_reset) rec_overrun_q <= 1'b0;
      else if (strobe_i && rec_full_i) rec_overrun_q <= 1'b1;  // sample lost
      ack_q <= cmd_i.any_access;
      if (cmd_i.sel_rec) rdata_q <= {16'b0, rec_half};
      else if (cmd_i.sel_status) rdata_q <= {{(32 - STAT_BITS){1'b0}}, status};
      else if (cmd_i.sel_codec) rdata_q <= {16'b0, codec_rdata_i};
      else if (cmd_i.sel_other) rdata_q <= '0;   // unmapped read
    end
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

//--- src/ac97_reg_pkg.sv
// Audio controller register map
`default_nettype none

package ac97_reg_pkg;
  import ac97_audio_pkg::*;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    logic      wen;                            // one-cycle write strobe
    logic      ren;                            // one-cycle read strobe
  } bus_req_t;

  typedef struct packed {
    bus_data_t rdata;
    logic      ack;
  } bus_rsp_t;

  // --------------------------------------------------------------------------
  // register offsets, low address bits only
  // --------------------------------------------------------------------------
  localparam int ADDR_DECODE_BITS = 20;
  typedef logic [ADDR_DECODE_BITS-1:0] reg_off_t;

  localparam reg_off_t ADDR_FIFO_PLAY   = 'h00;  // wo, left then right
  localparam reg_off_t ADDR_FIFO_REC    = 'h04;  // ro, left then right
  localparam reg_off_t ADDR_STATUS      = 'h08;  // ro
  localparam reg_off_t ADDR_FIFO_RESET  = 'h0C;  // wo
  localparam reg_off_t ADDR_CODEC_ADDR  = 'h10;  // wo, addr + rw flag
  localparam reg_off_t ADDR_CODEC_RDATA = 'h14;  // ro
  localparam reg_off_t ADDR_CODEC_WDATA = 'h18;  // wo

  // status byte layout
  localparam int STAT_BITS          = 8;
  localparam int STAT_PLAY_FULL     = 0;
  localparam int STAT_PLAY_HALF     = 1;       // count <= depth/2
  localparam int STAT_REC_FULL      = 2;
  localparam int STAT_REC_EMPTY     = 3;
  localparam int STAT_ACCESS_DONE   = 4;
  localparam int STAT_CODEC_READY   = 5;
  localparam int STAT_PLAY_UNDERRUN = 6;
  localparam int STAT_REC_OVERRUN   = 7;

  localparam int RST_PLAY_BIT = 0;
  localparam int RST_REC_BIT  = 1;
  localparam int CODEC_RW_BIT = 7;             // 1 = read from codec

  typedef logic [5:0]  codec_addr_t;           // word address
  typedef logic [15:0] codec_data_t;

  localparam codec_addr_t CODEC_PWR_WORD  = 6'h26 >> 1;  // power-down status
  localparam codec_data_t CODEC_PWR_READY = 16'h000F;    // all sub-blocks ready

  // decoded request, each flag valid for the request cycle only
  typedef struct packed {
    logic        play_push;                    // right write completes a pair
    stereo_t     play_pair;
    logic        rec_pop;                      // second record read
    logic        rec_half_right;
    logic        sel_status;
    logic        sel_rec;
    logic        sel_codec;
    logic        sel_other;                    // unmapped read
    logic        play_reset;
    logic        rec_reset;
    logic        codec_cmd_valid;
    codec_addr_t codec_addr;
    logic        codec_read;
    logic        codec_wdata_valid;
    codec_data_t codec_wdata;
    logic        any_access;                   // wen or ren
  } bus_cmd_t;

endpackage

`default_nettype wire

//--- src/codec_reg_file.sv
// Codec register shadow
`timescale 1ns/1ps
`default_nettype none

module codec_reg_file
  import ac97_reg_pkg::*;
(
  input  wire         clk_adc_125mhz,
  input  wire         adc_rstn_i,
  input  bus_cmd_t    cmd_i,
  output codec_data_t rdata_o,
  output logic        access_done_o
);

  localparam int CODEC_WORDS = 2 ** $bits(codec_addr_t);  // 64 words

  codec_data_t mem [CODEC_WORDS];
  codec_addr_t addr_q;                         // word under access
  codec_data_t wdata_q;                        // data for the next store
  codec_data_t rdata_q;
  logic        store_q;
  logic        recall_q;
  logic        prepare_q;                      // first stage of access

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      store_q       <= 1'b0;
      recall_q      <= 1'b0;
      prepare_q     <= 1'b0;
      access_done_o <= 1'b0;
      rdata_q       <= '0;
    end else begin
      store_q   <= cmd_i.codec_cmd_valid && !cmd_i.codec_read;
      recall_q  <= cmd_i.codec_cmd_valid && cmd_i.codec_read;
      prepare_q <= cmd_i.codec_cmd_valid;
      if (cmd_i.codec_cmd_valid) access_done_o <= 1'b0;  // new access pending
      else if (prepare_q) access_done_o <= 1'b1;
      if (recall_q) begin
        // power-down word always reports its sub-blocks ready
        if (addr_q == CODEC_PWR_WORD) rdata_q <= mem[addr_q] | CODEC_PWR_READY;
        else rdata_q <= mem[addr_q];
      end
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (cmd_i.codec_cmd_valid) addr_q <= cmd_i.codec_addr;
    if (cmd_i.codec_wdata_valid) wdata_q <= cmd_i.codec_wdata;
    if (store_q) mem[addr_q] <= wdata_q;
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/sample_fifo.sv
// Synchronous sample FIFO
`timescale 1ns/1ps
`default_nettype none

module sample_fifo
  import ac97_audio_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = FIFO_DEPTH_DEFAULT,
  parameter type         payload_t  = stereo_t
) (
  input  wire         clk_adc_125mhz,
  input  wire         adc_rstn_i,
  input  wire         flush_i,                 // empties the fifo at next clock
  input  wire         push_i,
  input  payload_t    data_i,
  input  wire         pop_i,
  output payload_t    head_o,                  // oldest word, no pop needed
  output fifo_count_t count_o,
  output logic        empty_o,
  output logic        full_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  typedef logic [PTR_W-1:0] ptr_t;

  payload_t    mem [FIFO_DEPTH];
  ptr_t        rd_ptr_q;
  ptr_t        wr_ptr_q;
  fifo_count_t count_q;
  logic        do_push;
  logic        do_pop;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_inc = (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;  // depth need not be 2^n
  endfunction

  assign full_o  = (count_q == fifo_count_t'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;          // dropped when full
  assign do_pop  = pop_i && !empty_o;          // ignored when empty
  assign head_o  = mem[rd_ptr_q];
  assign count_o = count_q;

  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;           // none, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/sample_strobe_gen.sv
// Sample-rate strobe divider
`timescale 1ns/1ps
`default_nettype none

module sample_strobe_gen #(
  parameter int unsigned SAMPLE_PERIOD = 2604  // 125 MHz / 48 kHz
) (
  input  wire  clk_adc_125mhz,
  input  wire  adc_rstn_i,
  output logic strobe_o                        // one cycle per sample
);

  localparam int unsigned CNT_W = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      cnt_q    <= '0;
      strobe_o <= 1'b0;
    end else if (cnt_q == CNT_W'(SAMPLE_PERIOD - 1)) begin
      cnt_q    <= '0;                          // wrap, fire strobe
      strobe_o <= 1'b1;
    end else begin
      cnt_q    <= cnt_q + 1'b1;
      strobe_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/ac97_vectors.txt
// op addr data expected in hex; op 1 write, 2 read with data as compare mask, 3 line in,
// 4 wait data strobes and check line out if addr is 1, f end of test addr, 0 last vector
// codec shadow, store then recall, power-down ready bits, unmapped read
1 18 00001234 00000000
1 10 0000000a 00000000
1 10 0000008a 00000000
2 08 00000030 00000030
2 14 ffffffff 00001234
1 18 00005a50 00000000
1 10 00000026 00000000
1 10 000000a6 00000000
2 08 00000010 00000010
2 14 ffffffff 00005a5f
2 1c ffffffff 00000000
f 01 00000000 00000000
// playback of three pairs, then underrun
4 00 00000001 00000000
1 0c 00000001 00000000
1 00 00001111 00000000
1 00 00002222 00000000
1 00 00003333 00000000
1 00 00004444 00000000
1 00 00008001 00000000
1 00 0000fffe 00000000
4 00 00000001 00000000
4 01 00000001 22221111
4 01 00000001 44443333
2 08 00000040 00000000
4 01 00000001 fffe8001
2 08 00000040 00000040
f 02 00000000 00000000
// record of three line inputs
4 00 00000001 00000000
1 0c 00000002 00000000
3 00 7fff8000 00000000
4 00 00000001 00000000
3 00 12345678 00000000
4 00 00000001 00000000
3 00 beef0101 00000000
4 00 00000001 00000000
2 04 ffffffff 00008000
2 04 ffffffff 00007fff
2 04 ffffffff 00005678
2 04 ffffffff 00001234
2 04 ffffffff 00000101
2 04 ffffffff 0000beef
2 08 0000000c 00000008
f 03 00000000 00000000
// record full and overrun
4 00 00000011 00000000
2 08 00000084 00000084
f 04 00000000 00000000
// fifo reset of both paths
4 00 00000001 00000000
1 0c 00000003 00000000
2 08 000000ff 0000003a
f 05 00000000 00000000
0 00 00000000 00000000

//--- tb/tb_ac97_ctrl.sv
// Audio controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ac97_ctrl
  import ac97_reg_pkg::*;
  import ac97_audio_pkg::*;
();

  localparam int unsigned SAMPLE_PERIOD = 40;
  localparam int unsigned FIFO_DEPTH    = 16;
  localparam int          MAX_VEC       = 80;
  localparam int          ACK_TIMEOUT   = 8;   // cycles to wait for ack
  localparam bit [31:0]   SEED          = 32'h669a_fec2;

  // vector operation codes
  localparam bus_data_t OP_LAST     = 32'h0;
  localparam bus_data_t OP_WRITE    = 32'h1;
  localparam bus_data_t OP_READ     = 32'h2;   // data column is the compare mask
  localparam bus_data_t OP_LINE_IN  = 32'h3;
  localparam bus_data_t OP_WAIT     = 32'h4;   // addr 1 checks line out after
  localparam bus_data_t OP_END_TEST = 32'hf;

  logic        clk_adc_125mhz;
  logic        adc_rstn;
  bus_addr_t   sys_addr;
  bus_data_t   sys_wdata;
  logic        sys_wen;
  logic        sys_ren;
  bus_data_t   sys_rdata;
  logic        sys_ack;
  stereo_t     line_in;
  stereo_t     line_out;
  logic        sample_strobe;

  bus_data_t   vec_mem [4*MAX_VEC];            // op, addr, data, expected
  int          n_vec;
  logic        vec_ready;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  int          tests_done;
  int unsigned seed_ret;
  bus_data_t   op;
  bus_data_t   vaddr;
  bus_data_t   vdata;
  bus_data_t   vexp;
  bus_data_t   rdata;

  tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk_gen (
    .clk_o(clk_adc_125mhz), .rstn_o(adc_rstn)
  );

  ac97_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .SAMPLE_PERIOD(SAMPLE_PERIOD)) UUT (
    .clk_adc_125mhz(clk_adc_125mhz), .adc_rstn_i(adc_rstn),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
    .sys_ren_i(sys_ren), .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack),
    .line_in_i(line_in), .line_out_o(line_out), .sample_strobe_o(sample_strobe)
  );

  // --------------------------------------------------------------------------
  // bus and strobe helpers
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic wr, input bus_addr_t addr,
                            input bus_data_t wdata, output bus_data_t data_o);
    int unsigned gap;
    int          waited;
    gap    = $urandom_range(2, 0);              // idle cycles before request
    waited = 0;
    data_o = '0;
    repeat (gap) @(posedge clk_adc_125mhz);
    @(posedge clk_adc_125mhz);
    sys_addr  <= addr;
    sys_wdata <= wdata;
    sys_wen   <= wr;
    sys_ren   <= !wr;
    @(posedge clk_adc_125mhz);
    sys_wen <= 1'b0;                            // one-cycle enables
    sys_ren <= 1'b0;
    @(negedge clk_adc_125mhz);
    while (!sys_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk_adc_125mhz);
      waited++;
    end
    if (!sys_ack) begin
      errors++;
      test_errors++;
      $display("no acknowledge from the DUT for the access to 0x%02h", addr[7:0]);
    end else begin
      data_o = sys_rdata;                       // stable at the falling edge
    end
  endtask

  task automatic wait_strobes(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk_adc_125mhz);
      if (sample_strobe) seen++;                // strobe takes effect next edge
    end
  endtask

  task automatic check_word(input bus_addr_t addr, input bus_data_t got,
                            input bus_data_t exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t: read 0x%02h gave 0x%08h, expected 0x%08h",
               $time, addr[7:0], got, exp);
    end
  endtask

  task automatic check_stereo(input stereo_t got, input stereo_t exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t: line out right/left 0x%04h/0x%04h, expected 0x%04h/0x%04h",
               $time, got.right, got.left, exp.right, exp.left);
    end
  endtask

  task automatic compare_strobe(input logic got, input logic exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t: sample strobe %0b, expected %0b", $time, got, exp);
    end
  endtask

  // strobe due every SAMPLE_PERIOD cycles counted from reset release
  initial begin
    int unsigned cyc;
    logic        due;
    cyc = 0;
    @(posedge adc_rstn);
    forever begin
      @(negedge clk_adc_125mhz);
      due = (cyc != 0) && (cyc % SAMPLE_PERIOD == 0);
      if (sample_strobe || due) compare_strobe(sample_strobe, due);
      cyc++;
    end
  end

  // --------------------------------------------------------------------------
  // vector sequencer
  // --------------------------------------------------------------------------
  initial begin
    sys_addr    = '0;
    sys_wdata   = '0;
    sys_wen     = 1'b0;
    sys_ren     = 1'b0;
    line_in     = '0;
    vec_ready   = 1'b0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    tests_done  = 0;
    seed_ret    = $urandom(SEED);               // one seed for the run
    $readmemh("tb/ac97_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && !$isunknown(vec_mem[4*n_vec])
           && vec_mem[4*n_vec] != OP_LAST) begin
      n_vec++;
    end
    vec_ready = 1'b1;
    if (n_vec == 0) begin
      errors++;
      $display("no vectors found in tb/ac97_vectors.txt");
    end
    while (adc_rstn !== 1'b1) @(posedge clk_adc_125mhz);
    for (int i = 0; i < n_vec; i++) begin
      op    = vec_mem[4*i];
      vaddr = vec_mem[4*i+1];
      vdata = vec_mem[4*i+2];
      vexp  = vec_mem[4*i+3];
      case (op)
        OP_WRITE: bus_access(1'b1, vaddr, vdata, rdata);
        OP_READ: begin
          bus_access(1'b0, vaddr, '0, rdata);
          check_word(vaddr, rdata & vdata, vexp & vdata);
        end
        OP_LINE_IN: begin
          @(posedge clk_adc_125mhz);
          line_in <= stereo_t'(vdata);
        end
        OP_WAIT: begin
          wait_strobes(int'(vdata));
          if (vaddr != '0) check_stereo(line_out, stereo_t'(vexp));
        end
        OP_END_TEST: begin
          $display("test %0d: %0d checks, %0d errors", vaddr, test_checks, test_errors);
          tests_done++;
          test_checks = 0;
          test_errors = 0;
        end
        default: begin
          errors++;
          $display("unknown operation 0x%0h in vector %0d", op, i);
        end
      endcase
    end
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog, four sample periods per vector
  initial begin
    wait (vec_ready);
    repeat ((n_vec + 1) * 4 * SAMPLE_PERIOD) @(posedge clk_adc_125mhz);
    $display("timeout: vectors did not complete within %0d sample periods",
             (n_vec + 1) * 4);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rstn_o                          // active low
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // 125 MHz at 8 ns
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstn_o <= 1'b1;                            // released on a rising edge
  end

endmodule

`default_nettype wire
